// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_modexp
RTL_TOP    := modexp_top
FILELIST   := list.f
BUILD_DIR  := obj_dir
LOG        := sim.log
SIM_FLAGS  := --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS := --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "Simulation PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: list.f
+incdir+include
logic/modexp_arith_pkg.sv
logic/modexp_ctrl_pkg.sv
logic/mont_mul.sv
logic/operand_bank.sv
logic/exp_sequencer.sv
logic/modexp_top.sv
sim/tb_modexp.sv

// File: logic/exp_sequencer.sv
//--------------------------------------------------
// square-and-multiply FSM over the exponent bits,
// msb first
//--------------------------------------------------

`timescale 1ns/1ns
`default_nettype none

module exp_sequencer
    import modexp_arith_pkg::*;
    import modexp_ctrl_pkg::*;
#(
    parameter int WIDTH = DEFAULT_WIDTH
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             start,
    input  logic [WIDTH-1:0] y,
    input  logic             mm_done,
    output logic             load,
    output logic             mm_start,
    output mm_op_t           mm_op,
    output logic             busy,
    output logic             done
);

    localparam int CW = bit_count_width(WIDTH);

    seq_state_t       state;
    logic [WIDTH-1:0] exp_q;
    logic [CW-1:0]    bit_cnt;
    logic             issue_q;
    logic             accept;
    logic             last_bit;
    logic             bit_end;

    assign accept   = start && (state == IDLE);
    assign last_bit = (bit_cnt == CW'(WIDTH - 1));

    // last step of the current exponent bit
    assign bit_end = mm_done &&
                     (((state == SQUARE) && !exp_q[WIDTH-1]) || (state == MULTIPLY));

    assign load     = accept;
    assign mm_start = issue_q;
    assign busy     = (state != IDLE);
    assign done     = (state == FINISH);

    always_comb begin
        case (state)
            TO_MONT:  mm_op = OP_TO_MONT;
            INIT_ACC: mm_op = OP_INIT_ACC;
            SQUARE:   mm_op = OP_SQUARE;
            MULTIPLY: mm_op = OP_MULTIPLY;
            default:  mm_op = OP_FROM_MONT;
        endcase
    end

    //--------------------------------------------------
    // exponent shift register and bit counter
    //--------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exp_q   <= '0;
            bit_cnt <= '0;
        end else if (accept) begin
            exp_q   <= y;
            bit_cnt <= '0;
        end else if (bit_end) begin
            exp_q   <= exp_q << 1;
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    //--------------------------------------------------
    // step FSM
    //--------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= IDLE;
            issue_q <= 1'b0;
        end else begin
            issue_q <= 1'b0;
            case (state)
                IDLE: begin
                    if (accept) begin
                        state   <= TO_MONT;
                        issue_q <= 1'b1;
                    end
                end
                TO_MONT: begin
                    if (mm_done) begin
                        state   <= INIT_ACC;
                        issue_q <= 1'b1;
                    end
                end
                INIT_ACC: begin
                    if (mm_done) begin
                        state   <= SQUARE;
                        issue_q <= 1'b1;
                    end
                end
                SQUARE, MULTIPLY: begin
                    if (mm_done) begin
                        issue_q <= 1'b1;
                        if (!bit_end) begin
                            // top bit set, multiply before moving on
                            state <= MULTIPLY;
                        end else if (last_bit) begin
                            state <= FROM_MONT;
                        end else begin
                            state <= SQUARE;
                        end
                    end
                end
                FROM_MONT: begin
                    if (mm_done) begin
                        state <= FINISH;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: logic/modexp_arith_pkg.sv
//--------------------------------------------------
// operand width default and counter sizing for the
// modular exponentiation datapath
//--------------------------------------------------

`default_nettype none

package modexp_arith_pkg;

    // operand width in bits, R = 2^WIDTH
    parameter int DEFAULT_WIDTH = 32;

    // width of a counter holding 0 .. width
    function automatic int bit_count_width(input int width);
        int bits;
        bits = $clog2(width + 1);
        if (bits < 1) begin
            bits = 1;
        end
        return bits;
    endfunction

endpackage

`default_nettype wire

// File: logic/modexp_ctrl_pkg.sv
//--------------------------------------------------
// multiplication step codes and sequencer states
//--------------------------------------------------

`default_nettype none

package modexp_ctrl_pkg;

    // which product is computed and where it lands
    typedef enum logic [2:0] {
        OP_TO_MONT   = 3'd0,
        OP_INIT_ACC  = 3'd1,
        OP_SQUARE    = 3'd2,
        OP_MULTIPLY  = 3'd3,
        OP_FROM_MONT = 3'd4
    } mm_op_t;

    typedef enum logic [2:0] {
        IDLE      = 3'd0,
        TO_MONT   = 3'd1,
        INIT_ACC  = 3'd2,
        SQUARE    = 3'd3,
        MULTIPLY  = 3'd4,
        FROM_MONT = 3'd5,
        FINISH    = 3'd6
    } seq_state_t;

endpackage

`default_nettype wire

// File: logic/modexp_top.sv
//--------------------------------------------------
// modular exponentiation top, result = x^y mod m
//--------------------------------------------------

`timescale 1ns/1ns
`default_nettype none

module modexp_top
    import modexp_arith_pkg::*;
    import modexp_ctrl_pkg::*;
#(
    parameter int WIDTH = DEFAULT_WIDTH
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             start,
    input  logic [WIDTH-1:0] x,
    input  logic [WIDTH-1:0] y,
    input  logic [WIDTH-1:0] m,
    input  logic [WIDTH-1:0] r2,
    output logic             busy,
    output logic             done,
    output logic [WIDTH-1:0] result
);

    logic             load;
    logic             mm_start;
    logic             mm_done;
    mm_op_t           mm_op;
    logic [WIDTH-1:0] op_a;
    logic [WIDTH-1:0] op_b;
    logic [WIDTH-1:0] modulus;
    logic [WIDTH-1:0] product;

    exp_sequencer #(.WIDTH(WIDTH)) u_seq (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .y        (y),
        .mm_done  (mm_done),
        .load     (load),
        .mm_start (mm_start),
        .mm_op    (mm_op),
        .busy     (busy),
        .done     (done)
    );

    operand_bank #(.WIDTH(WIDTH)) u_bank (
        .clk     (clk),
        .rst_n   (rst_n),
        .load    (load),
        .x       (x),
        .m       (m),
        .r2      (r2),
        .mm_op   (mm_op),
        .mm_done (mm_done),
        .product (product),
        .op_a    (op_a),
        .op_b    (op_b),
        .modulus (modulus),
        .acc     (result)
    );

    mont_mul #(.WIDTH(WIDTH)) u_mm (
        .clk      (clk),
        .rst_n    (rst_n),
        .mm_start (mm_start),
        .op_a     (op_a),
        .op_b     (op_b),
        .modulus  (modulus),
        .mm_done  (mm_done),
        .product  (product)
    );

endmodule

`default_nettype wire

// File: logic/mont_mul.sv
//--------------------------------------------------
// bit-serial radix-2 Montgomery multiplier
// product = a * b * 2^-WIDTH mod modulus
//--------------------------------------------------

`timescale 1ns/1ns
`default_nettype none

module mont_mul
    import modexp_arith_pkg::*;
#(
    parameter int WIDTH = DEFAULT_WIDTH
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             mm_start,
    input  logic [WIDTH-1:0] op_a,
    input  logic [WIDTH-1:0] op_b,
    input  logic [WIDTH-1:0] modulus,
    output logic             mm_done,
    output logic [WIDTH-1:0] product
);

    localparam int CW = bit_count_width(WIDTH);

    logic [WIDTH-1:0] a_q;
    logic [WIDTH-1:0] b_q;
    logic [WIDTH-1:0] m_q;
    logic [WIDTH+1:0] sum_q;
    logic [CW-1:0]    cnt_q;
    logic             active_q;
    logic [WIDTH+1:0] sum_b;
    logic [WIDTH+1:0] sum_m;
    logic [WIDTH+1:0] diff;
    logic             iter_done;

    assign iter_done = (cnt_q == CW'(WIDTH));

    // one radix-2 step: add b if bit set, make even, halve
    always_comb begin
        sum_b = sum_q + (a_q[0] ? {2'b00, b_q} : '0);
        sum_m = sum_b + (sum_b[0] ? {2'b00, m_q} : '0);
    end

    // final subtraction, sum is below 2m here
    assign diff    = sum_q - {2'b00, m_q};
    assign product = (sum_q >= {2'b00, m_q}) ? diff[WIDTH-1:0] : sum_q[WIDTH-1:0];
    assign mm_done = active_q && iter_done;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active_q <= 1'b0;
            cnt_q    <= '0;
        end else if (mm_start) begin
            active_q <= 1'b1;
            cnt_q    <= '0;
        end else if (active_q) begin
            if (iter_done) begin
                active_q <= 1'b0;
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    // operand and running sum registers
    always_ff @(posedge clk) begin
        if (mm_start) begin
            a_q   <= op_a;
            b_q   <= op_b;
            m_q   <= modulus;
            sum_q <= '0;
        end else if (active_q && !iter_done) begin
            a_q   <= a_q >> 1;
            sum_q <= sum_m >> 1;
        end
    end

endmodule

`default_nettype wire

// File: logic/operand_bank.sv
//--------------------------------------------------
// operand registers, per-step operand select and
// product write-back
//--------------------------------------------------

`timescale 1ns/1ns
`default_nettype none

module operand_bank
    import modexp_arith_pkg::*;
    import modexp_ctrl_pkg::*;
#(
    parameter int WIDTH = DEFAULT_WIDTH
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             load,
    input  logic [WIDTH-1:0] x,
    input  logic [WIDTH-1:0] m,
    input  logic [WIDTH-1:0] r2,
    input  mm_op_t           mm_op,
    input  logic             mm_done,
    input  logic [WIDTH-1:0] product,
    output logic [WIDTH-1:0] op_a,
    output logic [WIDTH-1:0] op_b,
    output logic [WIDTH-1:0] modulus,
    output logic [WIDTH-1:0] acc
);

    localparam logic [WIDTH-1:0] ONE = WIDTH'(1);

    logic [WIDTH-1:0] m_q;
    logic [WIDTH-1:0] r2_q;
    logic [WIDTH-1:0] x_q;
    logic [WIDTH-1:0] x_mont_q;
    logic [WIDTH-1:0] acc_q;

    // job constants, captured once per start
    always_ff @(posedge clk) begin
        if (load) begin
            m_q  <= m;
            r2_q <= r2;
            x_q  <= x;
        end
    end

    // x in montgomery form
    always_ff @(posedge clk) begin
        if (mm_done && (mm_op == OP_TO_MONT)) begin
            x_mont_q <= product;
        end
    end

    // accumulator, also the visible result
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc_q <= '0;
        end else if (mm_done && (mm_op != OP_TO_MONT)) begin
            acc_q <= product;
        end
    end

    //--------------------------------------------------
    // operand select per step
    //--------------------------------------------------
    always_comb begin
        case (mm_op)
            OP_TO_MONT: begin
                op_a = x_q;
                op_b = r2_q;
            end
            OP_INIT_ACC: begin
                // r2 * R^-1 = R mod m
                op_a = r2_q;
                op_b = ONE;
            end
            OP_SQUARE: begin
                op_a = acc_q;
                op_b = acc_q;
            end
            OP_MULTIPLY: begin
                op_a = acc_q;
                op_b = x_mont_q;
            end
            default: begin
                op_a = acc_q;
                op_b = ONE;
            end
        endcase
    end

    assign modulus = m_q;
    assign acc     = acc_q;

endmodule

`default_nettype wire

// File: sim/modexp_testdata.txt
// columns, all hex: m r2 x y expected
// r2 = 2^64 mod m, expected = x^y mod m
00000003 00000001 00000002 00000005 00000002
00000005 00000001 00000003 00000004 00000001
00000007 00000002 00000003 00000005 00000005
00000009 00000007 00000002 00000005 00000005
0000000b 00000005 00000007 00000003 00000002
0000000d 00000003 00000005 00000003 00000008
00000011 00000001 00000003 00000007 0000000b
000000ff 00000001 00000002 00000009 00000002
00000101 00000001 00000010 00000002 00000100
0000ffff 00000001 00001234 00000001 00001234
00010001 00000001 00000003 00010000 00000001
7fffffff 00000004 00000010 00000008 00000002
7fffffff 00000004 00000007 7ffffffe 00000001
7fffffff 00000004 7ffffffe 00000003 7ffffffe
3fffffff 00000010 00000002 00000028 00000400
40000001 00000010 00000002 0000001f 3fffffff

// File: include/tb_model.svh
//--------------------------------------------------
// reference model for the testbench: x^y mod m,
// r2 = R^2 mod m and an LCG
//--------------------------------------------------

`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

localparam logic [31:0] LCG_SEED = 32'h3ccd;

// square-and-multiply, m below 2^32 keeps products in 64 bits
function automatic longint unsigned modexp_model(input longint unsigned x,
                                                 input longint unsigned y,
                                                 input longint unsigned m);
    longint unsigned acc;
    acc = 1 % m;
    for (int i = 63; i >= 0; i--) begin
        acc = (acc * acc) % m;
        if (y[i]) begin
            acc = (acc * x) % m;
        end
    end
    return acc;
endfunction

// 2^(2*width) mod m by modular doubling
function automatic longint unsigned r2_model(input longint unsigned m, input int width);
    longint unsigned r;
    r = 1 % m;
    for (int i = 0; i < 2 * width; i++) begin
        r = (r << 1) % m;
    end
    return r;
endfunction

// next LCG state
function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
endfunction

`endif

// File: sim/tb_modexp.sv
//--------------------------------------------------
// testbench for modexp_top with file vectors, edge
// exponents, random jobs and a dropped start
//--------------------------------------------------

`timescale 1ns/1ns
`default_nettype none

module tb_modexp;

    localparam int WIDTH          = 32;
    localparam int NUM_VEC        = 16;
    localparam int NUM_EDGE       = 4;
    localparam int NUM_RAND       = 24;
    localparam int NUM_JOBS       = NUM_VEC + NUM_EDGE + NUM_RAND + 1;
    localparam int JOB_CYCLES     = (3 + 2 * WIDTH) * (WIDTH + 2);
    localparam int TIMEOUT_CYCLES = NUM_JOBS * JOB_CYCLES + 200;

    `include "tb_model.svh"

    logic             clk;
    logic             rst_n;
    logic             start;
    logic [WIDTH-1:0] x;
    logic [WIDTH-1:0] y;
    logic [WIDTH-1:0] m;
    logic [WIDTH-1:0] r2;
    logic             busy;
    logic             done;
    logic [WIDTH-1:0] result;

    // five words per row as m r2 x y expected
    logic [31:0] vec_mem [0:NUM_VEC*5-1];

    int          check_count;
    int          value_errors;
    int          other_errors;
    int          cycle_cnt;
    logic [31:0] lcg_state;

    modexp_top #(.WIDTH(WIDTH)) u_dut (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (start),
        .x      (x),
        .y      (y),
        .m      (m),
        .r2     (r2),
        .busy   (busy),
        .done   (done),
        .result (result)
    );

    always #20 clk = ~clk;

    // run limit
    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation FAILED");
            $finish;
        end
    end

    //--------------------------------------------------
    // helpers
    //--------------------------------------------------
    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        assert (actual === expected) else begin
            value_errors++;
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // one start pulse from just after a falling edge
    task automatic launch_job(input logic [31:0] m_in, input logic [31:0] r2_in,
                              input logic [31:0] x_in, input logic [31:0] y_in);
        m     = m_in;
        r2    = r2_in;
        x     = x_in;
        y     = y_in;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
    endtask

    task automatic finish_job(input string name, input logic [31:0] expected);
        int          waited;
        logic [31:0] held;
        waited = 0;
        while (done !== 1'b1 && waited < JOB_CYCLES) begin
            @(negedge clk);
            waited++;
        end
        check_count++;
        assert (done === 1'b1) else begin
            other_errors++;
            $display("%s: done did not arrive within %0d cycles", name, JOB_CYCLES);
        end
        if (done === 1'b1) begin
            check_value(name, expected, result);
            check_value({name, " busy on done"}, 32'd1, {31'd0, busy});
            held = result;
            @(negedge clk);
            check_value({name, " done one cycle"}, 32'd0, {31'd0, done});
            check_value({name, " busy after done"}, 32'd0, {31'd0, busy});
            check_value({name, " result held"}, held, result);
        end
    endtask

    task automatic run_job(input string name, input logic [31:0] m_in,
                           input logic [31:0] r2_in, input logic [31:0] x_in,
                           input logic [31:0] y_in, input logic [31:0] expected);
        check_value({name, " busy before start"}, 32'd0, {31'd0, busy});
        launch_job(m_in, r2_in, x_in, y_in);
        finish_job(name, expected);
    endtask

    function automatic logic [31:0] model_result(input logic [31:0] x_in,
                                                 input logic [31:0] y_in,
                                                 input logic [31:0] m_in);
        longint unsigned res;
        res = modexp_model(64'(x_in), 64'(y_in), 64'(m_in));
        return res[31:0];
    endfunction

    function automatic logic [31:0] model_r2(input logic [31:0] m_in);
        longint unsigned res;
        res = r2_model(64'(m_in), WIDTH);
        return res[31:0];
    endfunction

    //--------------------------------------------------
    // test groups
    //--------------------------------------------------
    task automatic run_file_vectors();
        string       name;
        logic [31:0] vm;
        logic [31:0] vr2;
        logic [31:0] vx;
        logic [31:0] vy;
        logic [31:0] vexp;
        for (int i = 0; i < NUM_VEC; i++) begin
            vm   = vec_mem[i*5];
            vr2  = vec_mem[i*5+1];
            vx   = vec_mem[i*5+2];
            vy   = vec_mem[i*5+3];
            vexp = vec_mem[i*5+4];
            name = $sformatf("vector %0d", i);
            check_value({name, " model"}, vexp, model_result(vx, vy, vm));
            check_value({name, " r2"}, vr2, model_r2(vm));
            run_job(name, vm, vr2, vx, vy, vexp);
        end
    endtask

    // y = 0 and y = 1 on a large and a small modulus
    task automatic run_edge_jobs();
        logic [31:0] em [0:1];
        logic [31:0] ex [0:1];
        logic [31:0] ey;
        logic [31:0] ee;
        string       name;
        em[0] = 32'h7fffffed;
        ex[0] = 32'h07654321;
        em[1] = 32'h0000000f;
        ex[1] = 32'h0000000e;
        for (int i = 0; i < NUM_EDGE; i++) begin
            ey   = 32'(i % 2);
            ee   = (ey == 0) ? 32'd1 : ex[i/2];
            name = $sformatf("edge m=%h y=%0d", em[i/2], ey);
            check_value({name, " model"}, ee, model_result(ex[i/2], ey, em[i/2]));
            run_job(name, em[i/2], model_r2(em[i/2]), ex[i/2], ey, ee);
        end
    endtask

    task automatic run_random_jobs();
        logic [31:0] rm;
        logic [31:0] rx;
        logic [31:0] ry;
        for (int i = 0; i < NUM_RAND; i++) begin
            lcg_state = lcg_next(lcg_state);
            rm        = (lcg_state & 32'h7fffffff) | 32'd1;
            if (rm == 32'd1) begin
                rm = 32'd3;
            end
            lcg_state = lcg_next(lcg_state);
            rx        = lcg_state % rm;
            lcg_state = lcg_next(lcg_state);
            ry        = lcg_state;
            run_job($sformatf("random %0d", i), rm, model_r2(rm), rx, ry,
                    model_result(rx, ry, rm));
        end
    endtask

    // second start while busy must not disturb the first job
    task automatic check_dropped_start();
        logic [31:0] m_a;
        logic [31:0] x_a;
        logic [31:0] y_a;
        logic [31:0] held;
        m_a = 32'h7fffffed;
        x_a = 32'h00012345;
        y_a = 32'hdeadbeef;
        check_value("dropped start busy before", 32'd0, {31'd0, busy});
        launch_job(m_a, model_r2(m_a), x_a, y_a);
        repeat (10) @(negedge clk);
        check_value("dropped start busy", 32'd1, {31'd0, busy});
        launch_job(32'h0000000b, 32'h00000005, 32'h00000007, 32'h00000003);
        finish_job("dropped start", model_result(x_a, y_a, m_a));
        held = result;
        for (int i = 0; i < 5; i++) begin
            @(negedge clk);
            check_value("dropped start result hold", held, result);
            check_value("dropped start done low", 32'd0, {31'd0, done});
        end
    endtask

    //--------------------------------------------------
    // main sequence
    //--------------------------------------------------
    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        start        = 1'b0;
        x            = '0;
        y            = '0;
        m            = '0;
        r2           = '0;
        check_count  = 0;
        value_errors = 0;
        other_errors = 0;
        cycle_cnt    = 0;
        lcg_state    = LCG_SEED;
        $readmemh("sim/modexp_testdata.txt", vec_mem);

        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_value("reset busy", 32'd0, {31'd0, busy});
        check_value("reset done", 32'd0, {31'd0, done});
        check_value("reset result", 32'd0, result);

        run_file_vectors();
        run_edge_jobs();
        run_random_jobs();
        check_dropped_start();

        $display("checks: %0d, value errors: %0d, other failures: %0d",
                 check_count, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
